/* design/addrgen_defines.svh */
// address generator width, step and fifo depth macros
`ifndef ADDRGEN_DEFINES_SVH
`define ADDRGEN_DEFINES_SVH

// bytes in one memory word, also the byte lanes of the strobe
`define ADDRGEN_STEP_BYTES 4

// byte address width on the memory port
`define ADDRGEN_ADDR_W 32

// width of the word, line and feature counters
`define ADDRGEN_CNT_W 10

// signed strides between lines and features
`define ADDRGEN_STRIDE_W 16

// raw beats held between producer and consumer
`define ADDRGEN_FIFO_DEPTH 4

`endif

/* design/addrgen_cfg_pkg.sv */
// configuration vector types and the job configuration struct
`default_nettype none

`include "addrgen_defines.svh"

package addrgen_cfg_pkg;

  // byte address, unaligned allowed
  typedef logic [`ADDRGEN_ADDR_W-1:0] addr_t;

  // signed byte distance, added as two's complement
  typedef logic signed [`ADDRGEN_STRIDE_W-1:0] stride_t;

  // loop count or loop index
  typedef logic [`ADDRGEN_CNT_W-1:0] count_t;

  // latched once per job on the start pulse
  typedef struct packed {
    addr_t   base_addr;   // byte address of word 0, line 0, feature 0
    count_t  line_length; // words per line
    stride_t line_stride; // bytes from one line to the next
    count_t  feat_length; // lines per feature
    stride_t feat_stride; // bytes from one feature offset to the next
    count_t  feat_total;  // features in the job
    count_t  feat_roll;   // features per roll period
    logic    loop_outer;  // 1: offset reused roll times, 0: offset wraps
  } addrgen_cfg_t;

  // outer mode:
  //   offset moves once every feat_roll features
  //   so each offset is walked feat_roll times in a row
  // inner mode:
  //   offset moves every feature
  //   back to zero once feat_roll features are done
  // feat_roll of 0 or 1 acts as a roll period of one

endpackage

`default_nettype wire

/* design/addrgen_beat_pkg.sv */
// beat types, the raw producer beat and the formatted output beat
`default_nettype none

`include "addrgen_defines.svh"

package addrgen_beat_pkg;

  import addrgen_cfg_pkg::*;

  // one bit per byte lane of a word
  typedef logic [`ADDRGEN_STEP_BYTES-1:0] strb_t;

  // producer to consumer, address still unaligned
  typedef struct packed {
    addr_t byte_addr;  // base + offsets, low bits kept
    logic  first;      // first beat of a line
    logic  last;       // last beat of a line
    logic  misaligned; // job needs partial strobes
    logic  final_beat; // last beat of the whole job
  } raw_beat_t;

  // what leaves on the memory port
  typedef struct packed {
    addr_t addr; // word aligned
    strb_t strb; // byte enables
  } out_beat_t;

  // misaligned lines carry one extra beat:
  //   first beat masks the lanes below the byte offset
  //   last beat keeps only those lanes

endpackage

`default_nettype wire

/* design/addrgen_loop_counter.sv */
// producer: word/line/feature loop counters and raw beat register
`timescale 1ns/1ps
`default_nettype none

`include "addrgen_defines.svh"

module addrgen_loop_counter
  import addrgen_cfg_pkg::*;
  import addrgen_beat_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  input  wire logic   start_i,      // single cycle, taken when idle
  input  addrgen_cfg_t cfg_i,
  output logic        busy_o,
  output logic        beat_valid_o,
  output raw_beat_t   beat_o,
  input  wire logic   beat_ready_i
);

  localparam int unsigned LOW_W = $clog2(`ADDRGEN_STEP_BYTES);

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } state_e;

  state_e       state_q;
  addrgen_cfg_t cfg_q;    // job config, held for the whole run
  addrgen_cfg_t cfg_sel;  // live config while starting, else latched
  logic         mis_sel;  // any of base / strides off word boundary
  count_t       len_sel;  // beats per line incl. the extra one
  logic         start_acc;
  logic         beat_acc;
  logic         word_last;
  logic         line_last;
  logic         roll_last;
  count_t       word_q, word_d; // position of the beat held in beat_o
  count_t       line_q, line_d;
  count_t       roll_q, roll_d; // index inside the roll period
  count_t       feat_q, feat_d; // features done so far
  addr_t        line_off_q, line_off_d;
  addr_t        feat_off_q, feat_off_d;
  raw_beat_t    beat_d;

  function automatic addr_t sext(stride_t s);
    return {{(`ADDRGEN_ADDR_W - `ADDRGEN_STRIDE_W){s[`ADDRGEN_STRIDE_W-1]}}, s};
  endfunction

  function automatic logic is_last(count_t idx, count_t len);
    return idx == count_t'(len - 1'b1);
  endfunction

  assign busy_o       = (state_q == ST_RUN);
  assign beat_valid_o = busy_o; // one beat always pending while running

  assign start_acc = (state_q == ST_IDLE) && start_i;
  assign beat_acc  = beat_valid_o && beat_ready_i;
  assign cfg_sel   = start_acc ? cfg_i : cfg_q;

  assign mis_sel = (|cfg_sel.base_addr[LOW_W-1:0]) ||
                   (|cfg_sel.line_stride[LOW_W-1:0]) ||
                   (|cfg_sel.feat_stride[LOW_W-1:0]);
  assign len_sel = cfg_sel.line_length + count_t'(mis_sel);

  // where the current beat sits in the loops
  assign word_last = is_last(word_q, len_sel);
  assign line_last = is_last(line_q, cfg_sel.feat_length);
  assign roll_last = (cfg_sel.feat_roll <= count_t'(1)) || is_last(roll_q, cfg_sel.feat_roll);

  // next loop position, innermost first
  always_comb begin
    word_d     = word_q;
    line_d     = line_q;
    roll_d     = roll_q;
    feat_d     = feat_q;
    line_off_d = line_off_q;
    feat_off_d = feat_off_q;
    if (start_acc) begin
      word_d     = '0;
      line_d     = '0;
      roll_d     = '0;
      feat_d     = '0;
      line_off_d = '0;
      feat_off_d = '0;
    end else if (beat_acc) begin
      if (!word_last) begin
        word_d = word_q + 1'b1;
      end else if (!line_last) begin
        word_d     = '0;
        line_d     = line_q + 1'b1;
        line_off_d = line_off_q + sext(cfg_sel.line_stride);
      end else begin
        // feature boundary
        word_d     = '0;
        line_d     = '0;
        line_off_d = '0;
        feat_d     = feat_q + 1'b1;
        roll_d     = roll_last ? '0 : roll_q + 1'b1;
        if (cfg_sel.loop_outer) begin
          if (roll_last) feat_off_d = feat_off_q + sext(cfg_sel.feat_stride);
        end else if (roll_last) begin
          feat_off_d = '0; // inner mode wraps
        end else begin
          feat_off_d = feat_off_q + sext(cfg_sel.feat_stride);
        end
      end
    end
  end

  // beat for the next position
  always_comb begin
    beat_d.byte_addr  = cfg_sel.base_addr + feat_off_d + line_off_d +
                        addr_t'(word_d) * addr_t'(`ADDRGEN_STEP_BYTES);
    beat_d.first      = (word_d == '0);
    beat_d.last       = is_last(word_d, len_sel);
    beat_d.misaligned = mis_sel;
    beat_d.final_beat = beat_d.last && is_last(line_d, cfg_sel.feat_length) &&
                        is_last(feat_d, cfg_sel.feat_total);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      word_q     <= '0;
      line_q     <= '0;
      roll_q     <= '0;
      feat_q     <= '0;
      line_off_q <= '0;
      feat_off_q <= '0;
    end else begin
      if (start_acc) state_q <= ST_RUN;
      else if (beat_acc && beat_o.final_beat) state_q <= ST_IDLE; // job handed off
      word_q     <= word_d;
      line_q     <= line_d;
      roll_q     <= roll_d;
      feat_q     <= feat_d;
      line_off_q <= line_off_d;
      feat_off_q <= feat_off_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_acc) cfg_q <= cfg_i;
    if (start_acc || beat_acc) beat_o <= beat_d; // held while stalled
  end

endmodule

`default_nettype wire

/* design/addrgen_beat_fifo.sv */
// circular fifo for raw beats with registered valid and ready-when-not-full
`timescale 1ns/1ps
`default_nettype none

`include "addrgen_defines.svh"

module addrgen_beat_fifo
  import addrgen_beat_pkg::*;
#(
  parameter int unsigned DEPTH = `ADDRGEN_FIFO_DEPTH
) (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  in_valid_i,
  input  raw_beat_t  in_beat_i,
  output logic       in_ready_o,
  output logic       out_valid_o,
  output raw_beat_t  out_beat_o,
  input  wire logic  out_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned OCC_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t; // slot index
  typedef logic [OCC_W-1:0] occ_t; // entries in use

  raw_beat_t mem_q [DEPTH];
  ptr_t      wr_ptr_q;
  ptr_t      rd_ptr_q;
  occ_t      count_q;
  logic      push;
  logic      pop;

  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1; // wraps for any depth
  endfunction

  assign in_ready_o  = (count_q != occ_t'(DEPTH)); // only full refuses
  assign out_valid_o = (count_q != '0);
  assign out_beat_o  = mem_q[rd_ptr_q]; // head slot, a register
  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      // occupancy
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or none
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_beat_i;
  end

endmodule

`default_nettype wire

/* design/addrgen_strobe_unit.sv */
// consumer: word alignment, byte strobe build and done pulse
`timescale 1ns/1ps
`default_nettype none

`include "addrgen_defines.svh"

module addrgen_strobe_unit
  import addrgen_beat_pkg::*;
(
  input  wire logic in_valid_i,
  input  raw_beat_t in_beat_i,
  output logic      in_ready_o,
  output logic      valid_o,
  output out_beat_t beat_o,
  input  wire logic ready_i,
  output logic      done_o
);

  localparam int unsigned LOW_W = $clog2(`ADDRGEN_STEP_BYTES);

  strb_t head_mask; // lanes at and above the byte offset

  assign head_mask = strb_t'('1) << in_beat_i.byte_addr[LOW_W-1:0];

  // handshake straight through, no storage here
  assign valid_o    = in_valid_i;
  assign in_ready_o = ready_i;

  // pulse with the transfer of the job's last beat
  assign done_o = in_valid_i && ready_i && in_beat_i.final_beat;

  always_comb begin
    beat_o.addr = in_beat_i.byte_addr;
    beat_o.addr[LOW_W-1:0] = '0; // word aligned
    beat_o.strb = '1;
    if (in_beat_i.misaligned) begin
      // offset is the same for every beat of a line
      if (in_beat_i.first) beat_o.strb = head_mask;
      if (in_beat_i.last) beat_o.strb = ~head_mask; // tail lanes only
    end
  end

  // aligned jobs:
  //   byte offset is zero, head_mask is all ones
  //   strobes stay full on every beat
  // misaligned jobs:
  //   line has line_length + 1 beats
  //   so first and last never land on the same beat

endmodule

`default_nettype wire

/* design/addrgen_top.sv */
// top level: loop counter, beat fifo and strobe unit
`timescale 1ns/1ps
`default_nettype none

`include "addrgen_defines.svh"

module addrgen_top
  import addrgen_cfg_pkg::*;
  import addrgen_beat_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire logic    start_i,
  input  addrgen_cfg_t cfg_i,
  output logic         busy_o,
  output logic         valid_o,
  output out_beat_t    beat_o,
  input  wire logic    ready_i,
  output logic         done_o
);

  logic      prod_busy;  // producer still walking loops
  logic      beat_valid;
  logic      beat_ready;
  raw_beat_t prod_beat;
  logic      fifo_valid; // beats still queued
  logic      fifo_ready;
  raw_beat_t fifo_beat;

  // job busy until producer done and fifo drained
  assign busy_o = prod_busy | fifo_valid;

  addrgen_loop_counter u_loop_counter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .cfg_i        (cfg_i),
    .busy_o       (prod_busy),
    .beat_valid_o (beat_valid),
    .beat_o       (prod_beat),
    .beat_ready_i (beat_ready)
  );

  addrgen_beat_fifo #(
    .DEPTH (`ADDRGEN_FIFO_DEPTH)
  ) u_beat_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (beat_valid),
    .in_beat_i   (prod_beat),
    .in_ready_o  (beat_ready),
    .out_valid_o (fifo_valid),
    .out_beat_o  (fifo_beat),
    .out_ready_i (fifo_ready)
  );

  addrgen_strobe_unit u_strobe_unit (
    .in_valid_i (fifo_valid),
    .in_beat_i  (fifo_beat),
    .in_ready_o (fifo_ready),
    .valid_o    (valid_o),
    .beat_o     (beat_o),
    .ready_i    (ready_i),
    .done_o     (done_o)
  );

endmodule

`default_nettype wire

/* sim/addrgen_asserts.sv */
// bound checks for output stall stability, done pulse and idle valid
`timescale 1ns/1ps
`default_nettype none

module addrgen_asserts
  import addrgen_beat_pkg::*;
(
  input wire logic clk_i,
  input wire logic rst_ni,
  input wire logic busy_i,
  input wire logic valid_i,
  input out_beat_t beat_i,
  input wire logic ready_i,
  input wire logic done_i
);

  int unsigned fail_cnt = 0; // assertion failures so far

  // stalled beat held until taken
  a_stall_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_i && !ready_i |=> valid_i && $stable(beat_i))
    else begin
      $error("output beat dropped or changed while stalled");
      fail_cnt++;
    end

  // done only with the transfer of the last beat, job over right after
  a_done_xfer : assert property (@(posedge clk_i) disable iff (!rst_ni)
      done_i |-> (valid_i && ready_i) ##1 !busy_i)
    else begin
      $error("done_o without a transfer or busy_o still high after it");
      fail_cnt++;
    end

  a_idle_quiet : assert property (@(posedge clk_i) disable iff (!rst_ni)
      !busy_i |=> !valid_i) // producer and fifo stage before any beat
    else begin
      $error("valid_o high right after busy_o was low");
      fail_cnt++;
    end

endmodule

bind addrgen_top addrgen_asserts u_addrgen_asserts (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .busy_i  (busy_o),
  .valid_i (valid_o),
  .beat_i  (beat_o),
  .ready_i (ready_i),
  .done_i  (done_o)
);

`default_nettype wire

/* sim/addrgen_tb.sv */
// testbench: job table, expected beat model, lfsr ready, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module addrgen_tb
  import addrgen_cfg_pkg::*;
  import addrgen_beat_pkg::*;
();

  typedef struct packed {
    addrgen_cfg_t cfg;
    logic         backpressure; // random ready_i when set
    logic [15:0]  beats;        // transfers expected for the job
  } test_row_t;

  localparam int NUM_TESTS = 7;

  // base, words, line stride, lines, feat stride, feats, roll, outer
  localparam test_row_t TESTS [NUM_TESTS] = '{
    '{'{32'h0000_1000, 10'd8, 16'sd0, 10'd1, 16'sd0, 10'd1, 10'd1, 1'b1}, 1'b0, 16'd8},
    '{'{32'h0000_2000, 10'd3, 16'sd64, 10'd3, -16'sd256, 10'd2, 10'd1, 1'b1}, 1'b1, 16'd18},
    '{'{32'h0000_2800, 10'd2, -16'sd32, 10'd4, 16'sd512, 10'd2, 10'd1, 1'b1}, 1'b1, 16'd16},
    '{'{32'h0000_3000, 10'd2, 16'sd16, 10'd2, 16'sd128, 10'd6, 10'd3, 1'b1}, 1'b1, 16'd24},
    '{'{32'h0000_3800, 10'd2, 16'sd16, 10'd2, 16'sd128, 10'd5, 10'd2, 1'b0}, 1'b0, 16'd20},
    '{'{32'h0000_4002, 10'd3, 16'sd32, 10'd2, 16'sd256, 10'd2, 10'd1, 1'b1}, 1'b0, 16'd16},
    '{'{32'h0000_5001, 10'd2, 16'sd19, 10'd3, -16'sd65, 10'd3, 10'd2, 1'b0}, 1'b1, 16'd27}
  };

  logic         clk_i;
  logic         rst_ni;
  logic         start_i;
  addrgen_cfg_t cfg_i;
  logic         busy_o;
  logic         valid_o;
  out_beat_t    beat_o;
  logic         ready_i;
  logic         done_o;

  logic [19:0]  lfsr;       // x^20 + x^17 + 1
  out_beat_t    exp_q [$];  // beats still owed by the DUT
  int unsigned  err_cnt;
  int unsigned  beat_cnt;

  addrgen_top u_addrgen_top (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start_i),
    .cfg_i   (cfg_i),
    .busy_o  (busy_o),
    .valid_o (valid_o),
    .beat_o  (beat_o),
    .ready_i (ready_i),
    .done_o  (done_o)
  );

  always #10 clk_i = ~clk_i; // 20 ns period

  function automatic logic [19:0] next_lfsr(logic [19:0] s);
    return {s[18:0], s[19] ^ s[16]};
  endfunction

  task automatic drive_ready(input logic random_ready);
    if (random_ready) begin
      lfsr    = next_lfsr(lfsr); // one step, one bit
      ready_i = lfsr[0];
    end else begin
      ready_i = 1'b1;
    end
  endtask

  // closed form of the nested loops, beat by beat
  task automatic build_expected(input addrgen_cfg_t c);
    logic      mis;
    int        len;
    int        roll;
    int        foff;
    addr_t     line_start;
    addr_t     byte_a;
    strb_t     head;
    out_beat_t exp;
    exp_q.delete();
    mis  = (c.base_addr[1:0] != 2'b00) || (c.line_stride[1:0] != 2'b00) ||
           (c.feat_stride[1:0] != 2'b00);
    len  = int'(c.line_length) + (mis ? 1 : 0); // extra beat per line
    roll = (c.feat_roll > 1) ? int'(c.feat_roll) : 1;
    for (int f = 0; f < int'(c.feat_total); f++) begin
      // outer reuses each offset roll times, inner wraps after roll
      foff = (c.loop_outer ? f / roll : f % roll) * int'(c.feat_stride);
      for (int l = 0; l < int'(c.feat_length); l++) begin
        line_start = c.base_addr + addr_t'(foff + l * int'(c.line_stride));
        head       = 4'b1111 << line_start[1:0];
        for (int w = 0; w < len; w++) begin
          byte_a   = line_start + addr_t'(w * 4);
          exp.addr = {byte_a[31:2], 2'b00};
          exp.strb = 4'b1111;
          if (mis && w == 0) exp.strb = head;
          else if (mis && w == len - 1) exp.strb = ~head; // tail lanes
          exp_q.push_back(exp);
        end
      end
    end
  endtask

  task automatic run_job(input int idx);
    test_row_t   row;
    out_beat_t   exp;
    int          cyc;
    int          first_cyc;
    int          nbeat;
    int unsigned errs_at_start;
    logic        finished;
    row           = TESTS[idx];
    errs_at_start = err_cnt;
    build_expected(row.cfg);
    assert (exp_q.size() == int'(row.beats)) else begin
      $display("[ERROR] %0t test %0d: model has %0d beats, table %0d", $time, idx,
               exp_q.size(), row.beats);
      err_cnt++;
    end
    cyc       = 0;
    first_cyc = -1;
    finished  = 1'b0;
    nbeat     = 0;
    @(posedge clk_i);
    #2;
    cfg_i   = row.cfg;
    start_i = 1'b1; // one cycle, DUT idle here
    drive_ready(row.backpressure);
    while (!finished) begin
      @(negedge clk_i); // outputs and ready_i settled
      if (cyc == 1) begin
        assert (busy_o) else begin
          $display("[ERROR] %0t test %0d: busy_o low after start", $time, idx);
          err_cnt++;
        end
      end
      if (valid_o && first_cyc < 0) first_cyc = cyc;
      if (valid_o && ready_i) begin
        exp = exp_q.pop_front();
        beat_cnt++;
        assert (beat_o == exp) else begin
          $display("[ERROR] %0t test %0d beat %0d: got %h/%b, expected %h/%b", $time, idx,
                   nbeat, beat_o.addr, beat_o.strb, exp.addr, exp.strb);
          err_cnt++;
        end
        assert (done_o == (exp_q.size() == 0)) else begin
          $display("[ERROR] %0t test %0d beat %0d: done_o is %b", $time, idx, nbeat, done_o);
          err_cnt++;
        end
        nbeat++;
        finished = (exp_q.size() == 0);
      end else begin
        assert (!done_o) else begin
          $display("[ERROR] %0t test %0d: done_o without a transfer", $time, idx);
          err_cnt++;
        end
      end
      if (!finished) begin
        @(posedge clk_i);
        #2;
        start_i = 1'b0;
        drive_ready(row.backpressure);
        cyc++;
      end
    end
    @(posedge clk_i);
    #2;
    ready_i = 1'b0;
    @(negedge clk_i);
    assert (!busy_o && !valid_o) else begin
      $display("[ERROR] %0t test %0d: busy_o or valid_o high after final", $time, idx);
      err_cnt++;
    end
    assert (first_cyc == 2) else begin
      $display("[ERROR] %0t test %0d: first valid_o after %0d cycles, expected 2", $time,
               idx, first_cyc);
      err_cnt++;
    end
    $display("test %0d: %0d beats, %0d errors", idx, nbeat, err_cnt - errs_at_start);
  endtask

  initial begin : watchdog
    int unsigned limit;
    limit = 16 + 200; // reset plus margin
    for (int i = 0; i < NUM_TESTS; i++) limit += TESTS[i].beats * 8 + 10;
    repeat (limit) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the DUT stopped delivering beats", limit);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    start_i  = 1'b0;
    cfg_i    = '0;
    ready_i  = 1'b0;
    lfsr     = 20'd99600;
    err_cnt  = 0;
    beat_cnt = 0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (!busy_o && !valid_o && !done_o) else begin
      $display("[ERROR] %0t outputs not idle after reset", $time);
      err_cnt++;
    end
    for (int i = 0; i < NUM_TESTS; i++) run_job(i);
    err_cnt += u_addrgen_top.u_addrgen_asserts.fail_cnt; // bound checks
    $display("summary: %0d tests, %0d beats, %0d errors", NUM_TESTS, beat_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/addrgen_cfg_pkg.sv
design/addrgen_beat_pkg.sv
design/addrgen_loop_counter.sv
design/addrgen_beat_fifo.sv
design/addrgen_strobe_unit.sv
design/addrgen_top.sv
sim/addrgen_asserts.sv
sim/addrgen_tb.sv
